/* hw/des_pkg.sv */
// DES widths, types, lookup tables and permutation functions imported by every RTL module
package des_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int BLOCK_W     = 64;
  localparam int HALF_W      = 32;
  localparam int KEY_HALF_W  = 28;
  localparam int ROUND_KEY_W = 48;
  localparam int NUM_ROUNDS  = 16;
  localparam int ROUND_W     = 4;
  localparam int NUM_SBOX    = 8;

  typedef logic [BLOCK_W-1:0]     block_t;
  typedef logic [HALF_W-1:0]      half_t;
  typedef logic [ROUND_KEY_W-1:0] round_key_t;
  typedef logic [ROUND_W-1:0]     round_t;

  // Feistel halves, l in the upper word
  typedef struct packed {
    half_t l;
    half_t r;
  } lr_t;

  typedef struct packed {
    logic [KEY_HALF_W-1:0] c;
    logic [KEY_HALF_W-1:0] d;
  } cd_t;

  // ------------------------------------------------
  // Tables, bit 1 is the MSB as in the standard
  // ------------------------------------------------
  localparam int IP_TABLE [BLOCK_W] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9,  1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam int FP_TABLE [BLOCK_W] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9,  49, 17, 57, 25
  };

  localparam int E_TABLE [ROUND_KEY_W] = '{
    32, 1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
    8,  9,  10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
  };

  localparam int P_TABLE [HALF_W] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1,  15, 23, 26, 5,  18, 31, 10,
    2,  8, 24, 14, 32, 27, 3,  9,  19, 13, 30, 6,  22, 11, 4,  25
  };

  localparam int PC1_TABLE [2*KEY_HALF_W] = '{
    57, 49, 41, 33, 25, 17, 9,  1,  58, 50, 42, 34, 26, 18,
    10, 2,  59, 51, 43, 35, 27, 19, 11, 3,  60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7,  62, 54, 46, 38, 30, 22,
    14, 6,  61, 53, 45, 37, 29, 21, 13, 5,  28, 20, 12, 4
  };

  localparam int PC2_TABLE [ROUND_KEY_W] = '{
    14, 17, 11, 24, 1,  5,  3,  28, 15, 6,  21, 10,
    23, 19, 12, 4,  26, 8,  16, 7,  27, 20, 13, 2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  // Left rotation per round, also used in reverse for decryption
  localparam int KEY_SHIFT [NUM_ROUNDS] = '{
    1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
  };

  // Index is {outer bits, inner four bits}, four rows of 16
  localparam logic [3:0] SBOX [NUM_SBOX][64] = '{
    '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
      0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
      4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
      15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
    '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
      3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
      0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
      13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
    '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
      13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
      13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
      1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
    '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
      13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
      10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
      3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
    '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
      14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
      4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
      11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
    '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
      10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
      9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
      4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
    '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
      13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
      1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
      6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
    '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
      1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
      7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
      2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
  };

  // ------------------------------------------------
  // Permutations
  // ------------------------------------------------
  function automatic block_t ip_perm(input block_t din);
    block_t dout;
    for (int i = 0; i < BLOCK_W; i++) begin
      dout[BLOCK_W-1-i] = din[BLOCK_W-IP_TABLE[i]];
    end
    return dout;
  endfunction

  function automatic block_t fp_perm(input block_t din);
    block_t dout;
    for (int i = 0; i < BLOCK_W; i++) begin
      dout[BLOCK_W-1-i] = din[BLOCK_W-FP_TABLE[i]];
    end
    return dout;
  endfunction

  function automatic round_key_t e_expand(input half_t din);
    round_key_t dout;
    for (int i = 0; i < ROUND_KEY_W; i++) begin
      dout[ROUND_KEY_W-1-i] = din[HALF_W-E_TABLE[i]];
    end
    return dout;
  endfunction

  function automatic half_t p_perm(input half_t din);
    half_t dout;
    for (int i = 0; i < HALF_W; i++) begin
      dout[HALF_W-1-i] = din[HALF_W-P_TABLE[i]];
    end
    return dout;
  endfunction

  // Parity bits of the key are dropped here
  function automatic cd_t pc1_perm(input block_t key);
    logic [2*KEY_HALF_W-1:0] cd;
    for (int i = 0; i < 2*KEY_HALF_W; i++) begin
      cd[2*KEY_HALF_W-1-i] = key[BLOCK_W-PC1_TABLE[i]];
    end
    return cd_t'(cd);
  endfunction

  function automatic round_key_t pc2_perm(input cd_t cd);
    logic [2*KEY_HALF_W-1:0] flat;
    round_key_t              dout;
    flat = cd;
    for (int i = 0; i < ROUND_KEY_W; i++) begin
      dout[ROUND_KEY_W-1-i] = flat[2*KEY_HALF_W-PC2_TABLE[i]];
    end
    return dout;
  endfunction

endpackage

/* hw/des_control.sv */
// Round sequencer for the DES core, accepts a strobe when idle and runs the 16 rounds
`timescale 1ns/1ps

module des_control (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            encipher_en,
  input  logic            decipher_en,
  output logic            start,
  output logic            decrypt,
  output des_pkg::round_t round,
  output logic            round_en,
  output logic            ready
);
  import des_pkg::*;

  logic decrypt_q;
  logic last_round;

  assign ready = ~round_en;

  // Strobes while busy are simply dropped
  assign start = ready & (encipher_en | decipher_en);

  // Encipher wins when both strobes arrive together
  assign decrypt = start ? (decipher_en & ~encipher_en) : decrypt_q;

  assign last_round = (round == round_t'(NUM_ROUNDS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      round_en <= 1'b0;
    end else if (start) begin
      round_en <= 1'b1;
    end else if (round_en && last_round) begin
      round_en <= 1'b0;
    end
  end

  // Wraps back to zero on the last round edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      round <= '0;
    end else if (start) begin
      round <= '0;
    end else if (round_en) begin
      round <= round + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      decrypt_q <= 1'b0;
    end else if (start) begin
      decrypt_q <= decrypt;
    end
  end

endmodule

/* hw/des_key_schedule.sv */
// DES key schedule with PC1 load, per-round C/D rotation and the PC2 subkey output
`timescale 1ns/1ps

module des_key_schedule (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                decrypt,
  input  logic                round_en,
  input  des_pkg::round_t     round,
  input  des_pkg::block_t     key_in,
  output des_pkg::round_key_t round_key
);
  import des_pkg::*;

  cd_t    cd_q;
  cd_t    cd_load;
  round_t shift_idx;
  logic   shift_two;

  function automatic logic [KEY_HALF_W-1:0] rot_left(
    input logic [KEY_HALF_W-1:0] v,
    input logic                  two
  );
    return two ? {v[KEY_HALF_W-3:0], v[KEY_HALF_W-1:KEY_HALF_W-2]}
               : {v[KEY_HALF_W-2:0], v[KEY_HALF_W-1]};
  endfunction

  function automatic logic [KEY_HALF_W-1:0] rot_right(
    input logic [KEY_HALF_W-1:0] v,
    input logic                  two
  );
    return two ? {v[1:0], v[KEY_HALF_W-1:2]}
               : {v[0], v[KEY_HALF_W-1:1]};
  endfunction

  // Encrypt looks ahead to the next round, decrypt undoes the round just used
  assign shift_idx = decrypt ? ~round : round + 1'b1;
  assign shift_two = (KEY_SHIFT[shift_idx] == 2);

  // C0/D0 unrotated is already the round 16 state for decryption
  always_comb begin
    cd_load = pc1_perm(key_in);
    if (!decrypt) begin
      cd_load.c = rot_left(cd_load.c, KEY_SHIFT[0] == 2);
      cd_load.d = rot_left(cd_load.d, KEY_SHIFT[0] == 2);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cd_q <= '0;
    end else if (start) begin
      cd_q <= cd_load;
    end else if (round_en) begin
      if (decrypt) begin
        cd_q.c <= rot_right(cd_q.c, shift_two);
        cd_q.d <= rot_right(cd_q.d, shift_two);
      end else begin
        cd_q.c <= rot_left(cd_q.c, shift_two);
        cd_q.d <= rot_left(cd_q.d, shift_two);
      end
    end
  end

  assign round_key = pc2_perm(cd_q);

endmodule

/* hw/des_feistel_f.sv */
// Combinational DES round function f(R, K) built from expansion, S-boxes and P
`timescale 1ns/1ps

module des_feistel_f (
  input  des_pkg::half_t      r_half,
  input  des_pkg::round_key_t round_key,
  output des_pkg::half_t      f_out
);
  import des_pkg::*;

  round_key_t mixed;
  half_t      s_out;

  assign mixed = e_expand(r_half) ^ round_key;

  // ------------------------------------------------
  // S-box substitution, 6 bits in and 4 bits out each
  // ------------------------------------------------
  for (genvar g = 0; g < NUM_SBOX; g++) begin : g_sbox
    logic [5:0] grp;

    assign grp = mixed[ROUND_KEY_W-1-6*g -: 6];
    // Row from the outer bits, column from the inner four
    assign s_out[HALF_W-1-4*g -: 4] = SBOX[g][{grp[5], grp[0], grp[4:1]}];
  end

  assign f_out = p_perm(s_out);

endmodule

/* hw/des_block_reg.sv */
// L/R half-block register of the DES core with IP on load and FP on the result
`timescale 1ns/1ps

module des_block_reg (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  input  logic            round_en,
  input  des_pkg::block_t data_in,
  input  des_pkg::half_t  f_out,
  output des_pkg::half_t  r_half,
  output des_pkg::block_t result
);
  import des_pkg::*;

  lr_t lr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lr_q <= '0;
    end else if (start) begin
      lr_q <= lr_t'(ip_perm(data_in));
    end else if (round_en) begin
      lr_q.l <= lr_q.r;
      lr_q.r <= lr_q.l ^ f_out;
    end
  end

  assign r_half = lr_q.r;

  // Last round has no swap, so R16 goes on top
  assign result = fp_perm({lr_q.r, lr_q.l});

endmodule

/* hw/des_core.sv */
// Top of the iterative DES engine, one Feistel round per clock in either direction
`timescale 1ns/1ps

module des_core (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            des_encipher_en,
  input  logic            des_decipher_en,
  input  des_pkg::block_t des_data,
  input  des_pkg::block_t des_key_in,
  output logic            desc_ready,
  output des_pkg::block_t desc_result
);
  import des_pkg::*;

  logic       start;
  logic       decrypt;
  logic       round_en;
  round_t     round;
  round_key_t round_key;
  half_t      r_half;
  half_t      f_out;

  des_control u_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .encipher_en (des_encipher_en),
    .decipher_en (des_decipher_en),
    .start       (start),
    .decrypt     (decrypt),
    .round       (round),
    .round_en    (round_en),
    .ready       (desc_ready)
  );

  des_key_schedule u_key_schedule (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .decrypt   (decrypt),
    .round_en  (round_en),
    .round     (round),
    .key_in    (des_key_in),
    .round_key (round_key)
  );

  des_feistel_f u_feistel (
    .r_half    (r_half),
    .round_key (round_key),
    .f_out     (f_out)
  );

  des_block_reg u_block (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .round_en (round_en),
    .data_in  (des_data),
    .f_out    (f_out),
    .r_half   (r_half),
    .result   (desc_result)
  );

endmodule

/* verif/tb_des_core.sv */
// Self-checking testbench for des_core that runs file vectors, busy strobes and random round trips
`timescale 1ns/1ps

module tb_des_core;
  import des_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int NUM_VECTORS = 10;
  localparam int NUM_RANDOM  = 8;
  localparam int OP_LIMIT    = 40;
  localparam int WATCHDOG_NS = (NUM_VECTORS + 2 * NUM_RANDOM + 4) * 20 * CLK_PERIOD;

  logic   clk;
  logic   rst_n;
  logic   des_encipher_en;
  logic   des_decipher_en;
  block_t des_data;
  block_t des_key_in;
  logic   desc_ready;
  block_t desc_result;

  // Four words per entry in the order mode, key, input, expected
  block_t vec_mem [4*NUM_VECTORS];
  integer seed   = 35159;
  int     errors = 0;
  int     checks = 0;

  des_core u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .des_encipher_en (des_encipher_en),
    .des_decipher_en (des_decipher_en),
    .des_data        (des_data),
    .des_key_in      (des_key_in),
    .desc_ready      (desc_ready),
    .desc_result     (desc_result)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  // --------------------------------------------------
  // Checkers and operation driver
  // --------------------------------------------------
  task automatic compare_block(input string name, input block_t expected, input block_t actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic verify_count(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("** Error at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  function automatic int first_entry_with_mode(input block_t mode);
    int found;
    found = 0;
    for (int v = NUM_VECTORS - 1; v >= 0; v--) begin
      if (vec_mem[4*v] == mode) begin
        found = v;
      end
    end
    return found;
  endfunction

  // Entered and left 2 ns after a rising edge
  task automatic run_operation(
    input  logic   enc,
    input  logic   dec,
    input  block_t key,
    input  block_t data,
    input  logic   check_result,
    input  block_t expected,
    input  logic   intrude,
    output block_t result
  );
    int low_cycles;
    low_cycles      = 0;
    des_encipher_en = enc;
    des_decipher_en = dec;
    des_key_in      = key;
    des_data        = data;
    @(posedge clk);
    #(DRIVE_DELAY);
    des_encipher_en = 1'b0;
    des_decipher_en = 1'b0;
    verify_count("desc_ready after start", 0, int'(desc_ready));
    while (desc_ready !== 1'b1 && low_cycles < OP_LIMIT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      low_cycles++;
      // Late strobes of both kinds with different operands
      if (intrude) begin
        des_decipher_en = (low_cycles == 4);
        des_encipher_en = (low_cycles == 8);
        if (low_cycles == 4) begin
          des_data   = ~data;
          des_key_in = ~key;
        end
      end
    end
    checks++;
    assert (desc_ready === 1'b1) else begin
      errors++;
      $display("Operation did not finish, desc_ready stayed low for %0d cycles", OP_LIMIT);
    end
    verify_count("desc_ready low cycles", NUM_ROUNDS, low_cycles);
    if (check_result) begin
      compare_block("desc_result", expected, desc_result);
    end
    result = desc_result;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    block_t key;
    block_t data;
    block_t cipher;
    block_t unused;
    int     idx;
    rst_n           = 1'b0;
    des_encipher_en = 1'b0;
    des_decipher_en = 1'b0;
    des_data        = '0;
    des_key_in      = '0;
    for (int i = 0; i < 4 * NUM_VECTORS; i++) begin
      vec_mem[i] = ~block_t'(i);
    end
    $readmemh("verif/des_vectors.txt", vec_mem);

    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    verify_count("desc_ready", 1, int'(desc_ready));
    compare_block("desc_result", '0, desc_result);

    for (int v = 0; v < NUM_VECTORS; v++) begin
      checks++;
      assert (vec_mem[4*v] <= 1) else begin
        errors++;
        $display("Vector file entry %0d is missing or has a bad mode word", v);
      end
    end

    // Known answers in both directions
    for (int v = 0; v < NUM_VECTORS; v++) begin
      run_operation(vec_mem[4*v] == 0, vec_mem[4*v] == 1, vec_mem[4*v+1], vec_mem[4*v+2],
                    1'b1, vec_mem[4*v+3], 1'b0, unused);
    end

    // Strobes while busy must be dropped
    idx = first_entry_with_mode(0);
    run_operation(1'b1, 1'b0, vec_mem[4*idx+1], vec_mem[4*idx+2], 1'b1, vec_mem[4*idx+3],
                  1'b1, unused);
    idx = first_entry_with_mode(1);
    run_operation(1'b0, 1'b1, vec_mem[4*idx+1], vec_mem[4*idx+2], 1'b1, vec_mem[4*idx+3],
                  1'b1, unused);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      key  = {$random(seed), $random(seed)};
      data = {$random(seed), $random(seed)};
      run_operation(1'b1, 1'b0, key, data, 1'b0, '0, 1'b0, cipher);
      run_operation(1'b0, 1'b1, key, cipher, 1'b1, data, 1'b0, unused);
    end

    // Both strobes together encrypt
    idx = first_entry_with_mode(0);
    run_operation(1'b1, 1'b1, vec_mem[4*idx+1], vec_mem[4*idx+2], 1'b1, vec_mem[4*idx+3],
                  1'b0, unused);

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verif/des_vectors.txt */
// mode key input expected, one entry per line, all hex
// mode 0 encrypts input, mode 1 decrypts it
0 133457799BBCDFF1 0123456789ABCDEF 85E813540F0AB405
1 133457799BBCDFF1 85E813540F0AB405 0123456789ABCDEF
0 0E329232EA6D0D73 8787878787878787 0000000000000000
1 0E329232EA6D0D73 0000000000000000 8787878787878787
0 0123456789ABCDEF 4E6F772069732074 3FA40E8A984D4815
1 0123456789ABCDEF 3FA40E8A984D4815 4E6F772069732074
0 0000000000000000 0000000000000000 8CA64DE9C1B123A7
1 0000000000000000 8CA64DE9C1B123A7 0000000000000000
0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7359B2163E4EDC58
1 FFFFFFFFFFFFFFFF 7359B2163E4EDC58 FFFFFFFFFFFFFFFF

/* filelist.f */
hw/des_pkg.sv
hw/des_control.sv
hw/des_key_schedule.sv
hw/des_feistel_f.sv
hw/des_block_reg.sv
hw/des_core.sv
verif/tb_des_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_des_core
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
